// File: fprint_defines.svh
`ifndef FPRINT_DEFINES_SVH
`define FPRINT_DEFINES_SVH

// task slots and task id width
`define FP_TASKS 4
`define FP_TASK_W 2

// fingerprint width
`define FP_CRC_W 16

// per task and core buffer
`define FP_CORES 3
`define FP_DEPTH 4
`define FP_PTR_W 2
`define FP_CNT_W 3

// host credits toward the status output
`define FP_STATUS_CREDITS 2
`define FP_CREDIT_W 2

`endif

// File: fprint_pkg.sv
`include "fprint_defines.svh"

package fprint_pkg;

	// comparator sequencing
	typedef enum logic [3:0] {
		st_idle,
		st_set_task,
		st_check_task,
		st_compare,
		st_pop_heads,
		st_record_fault,
		st_flush_task,
		st_write_status
	} cmp_state_t;

	// one record per finished task
	// core 3 means unknown or no fault
	typedef struct packed {
		logic [`FP_TASK_W-1:0] task_id;
		logic [1:0] core;
		logic mismatch;
	} status_rec_t;

endpackage

// File: fprint_task_if.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

interface fprint_task_if;

	// comparator side
	logic [`FP_TASK_W-1:0] task_id;
	logic pop_req;
	logic flush_req;

	// heads of the selected task
	logic [`FP_CRC_W-1:0] head0;
	logic [`FP_CRC_W-1:0] head1;
	logic [`FP_CRC_W-1:0] head2;

	// per task status
	logic [`FP_TASKS-1:0] ready;
	logic [`FP_TASKS-1:0] checkin;

	// selected task only
	logic remaining;
	logic [1:0] remaining_core;

	logic pop_ack;
	logic flush_ack;

	modport store (
		input task_id, pop_req, flush_req,
		output head0, head1, head2, ready, checkin,
		output remaining, remaining_core, pop_ack, flush_ack
	);

	modport comparator (
		output task_id, pop_req, flush_req,
		input head0, head1, head2, ready, checkin,
		input remaining, remaining_core, pop_ack, flush_ack
	);

endinterface

// File: fprint_store.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_store (
	input logic clk,
	input logic reset,
	input logic mode_tmr,
	input logic fp_valid,
	input logic [1:0] fp_core,
	input logic [`FP_TASK_W-1:0] fp_task,
	input logic [`FP_CRC_W-1:0] fp_crc,
	input logic done_valid,
	input logic [1:0] done_core,
	input logic [`FP_TASK_W-1:0] done_task,
	fprint_task_if.store task_bus,
	output logic overflow_error
);

	logic [`FP_CRC_W-1:0] mem [`FP_TASKS][`FP_CORES][`FP_DEPTH];
	logic [`FP_PTR_W-1:0] wr_ptr [`FP_TASKS][`FP_CORES];
	logic [`FP_PTR_W-1:0] rd_ptr [`FP_TASKS][`FP_CORES];
	logic [`FP_CNT_W-1:0] count [`FP_TASKS][`FP_CORES];
	logic [`FP_CORES-1:0] done [`FP_TASKS];
	logic [`FP_CORES-1:0] has_data [`FP_TASKS];
	logic wr_en [`FP_TASKS][`FP_CORES];
	logic rd_en [`FP_TASKS][`FP_CORES];
	logic [`FP_CORES-1:0] active;
	logic core_ok;
	logic buf_full;
	logic wr_ok;
	logic pop_go;
	logic flush_go;

	// DMR uses cores 0 and 1
	assign active = mode_tmr ? 3'b111 : 3'b011;

	// writes from inactive or invalid cores are ignored
	assign core_ok = (fp_core != 2'd3) && active[fp_core];
	assign buf_full = (count[fp_task][fp_core] == `FP_CNT_W'(`FP_DEPTH));
	assign wr_ok = fp_valid && core_ok && !buf_full;

	// act once per request with the ack in the next cycle
	assign pop_go = task_bus.pop_req && !task_bus.pop_ack;
	assign flush_go = task_bus.flush_req && !task_bus.flush_ack;

	always_comb begin
		for (int t = 0; t < `FP_TASKS; t++) begin
			for (int c = 0; c < `FP_CORES; c++) begin
				wr_en[t][c] = wr_ok && (fp_task == t) && (fp_core == c);
				rd_en[t][c] = pop_go && (task_bus.task_id == t) && active[c]
					&& (count[t][c] != '0);
				has_data[t][c] = active[c] && (count[t][c] != '0);
			end
			task_bus.ready[t] = (has_data[t] == active);
			task_bus.checkin[t] = ((done[t] & active) == active);
		end
	end

	assign task_bus.remaining = |has_data[task_bus.task_id];

	// lowest core still holding entries
	always_comb begin
		if (has_data[task_bus.task_id][0])
			task_bus.remaining_core = 2'd0;
		else if (has_data[task_bus.task_id][1])
			task_bus.remaining_core = 2'd1;
		else if (has_data[task_bus.task_id][2])
			task_bus.remaining_core = 2'd2;
		else
			task_bus.remaining_core = 2'd3;
	end

	assign task_bus.head0 = mem[task_bus.task_id][0][rd_ptr[task_bus.task_id][0]];
	assign task_bus.head1 = mem[task_bus.task_id][1][rd_ptr[task_bus.task_id][1]];
	assign task_bus.head2 = mem[task_bus.task_id][2][rd_ptr[task_bus.task_id][2]];

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[fp_task][fp_core][wr_ptr[fp_task][fp_core]] <= fp_crc;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int t = 0; t < `FP_TASKS; t++) begin
				for (int c = 0; c < `FP_CORES; c++) begin
					wr_ptr[t][c] <= '0;
					rd_ptr[t][c] <= '0;
					count[t][c] <= '0;
				end
				done[t] <= '0;
			end
			task_bus.pop_ack <= 1'b0;
			task_bus.flush_ack <= 1'b0;
			overflow_error <= 1'b0;
		end else begin
			task_bus.pop_ack <= pop_go;
			task_bus.flush_ack <= flush_go;
			// sticky flag while the entry itself is dropped
			if (fp_valid && core_ok && buf_full)
				overflow_error <= 1'b1;
			for (int t = 0; t < `FP_TASKS; t++) begin
				for (int c = 0; c < `FP_CORES; c++) begin
					if (flush_go && (task_bus.task_id == t)) begin
						wr_ptr[t][c] <= '0;
						rd_ptr[t][c] <= '0;
						count[t][c] <= '0;
					end else begin
						if (wr_en[t][c])
							wr_ptr[t][c] <= wr_ptr[t][c] + 1'b1;
						if (rd_en[t][c])
							rd_ptr[t][c] <= rd_ptr[t][c] + 1'b1;
						count[t][c] <= count[t][c] + `FP_CNT_W'(wr_en[t][c])
							- `FP_CNT_W'(rd_en[t][c]);
					end
				end
				// flush also clears the check-in
				if (flush_go && (task_bus.task_id == t))
					done[t] <= '0;
				else if (done_valid && (done_task == t) && (done_core != 2'd3))
					done[t][done_core] <= 1'b1;
			end
		end
	end

endmodule

// File: fprint_comparator.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_comparator (
	input logic clk,
	input logic reset,
	input logic mode_tmr,
	fprint_task_if.comparator task_bus,
	output logic status_write,
	output fprint_pkg::status_rec_t status_rec,
	input logic status_ack
);

	fprint_pkg::cmp_state_t state;
	logic [`FP_TASK_W-1:0] task_q;
	logic [1:0] core_q;
	logic mismatch_q;
	logic [`FP_TASK_W-1:0] pick_task;
	logic pick_valid;
	logic m01;
	logic m12;
	logic m20;
	logic heads_match;
	logic [1:0] blame_core;

	// lowest numbered task with work or a check-in
	always_comb begin
		pick_valid = 1'b0;
		pick_task = '0;
		for (int t = `FP_TASKS - 1; t >= 0; t--) begin
			if (task_bus.ready[t] || task_bus.checkin[t]) begin
				pick_valid = 1'b1;
				pick_task = `FP_TASK_W'(t);
			end
		end
	end

	assign m01 = (task_bus.head0 == task_bus.head1);
	assign m12 = (task_bus.head1 == task_bus.head2);
	assign m20 = (task_bus.head2 == task_bus.head0);
	assign heads_match = m01 && ((m12 && m20) || !mode_tmr);

	// majority vote over the three heads in TMR
	always_comb begin
		if (!mode_tmr)
			blame_core = 2'd3;
		else if (m12 && !m01)
			blame_core = 2'd0;
		else if (m20 && !m01)
			blame_core = 2'd1;
		else if (m01 && !m12)
			blame_core = 2'd2;
		else
			blame_core = 2'd3;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= fprint_pkg::st_idle;
			task_q <= '0;
			core_q <= 2'd3;
			mismatch_q <= 1'b0;
		end else begin
			case (state)
				fprint_pkg::st_idle: begin
					core_q <= 2'd3;
					mismatch_q <= 1'b0;
					if (pick_valid)
						state <= fprint_pkg::st_set_task;
				end
				fprint_pkg::st_set_task: begin
					// hold the task for the whole sequence
					task_q <= pick_task;
					state <= fprint_pkg::st_check_task;
				end
				fprint_pkg::st_check_task: begin
					if (task_bus.ready[task_q]) begin
						state <= fprint_pkg::st_compare;
					end else if (task_bus.checkin[task_q] && task_bus.remaining) begin
						// uneven counts after check-in
						core_q <= task_bus.remaining_core;
						state <= fprint_pkg::st_record_fault;
					end else if (task_bus.checkin[task_q]) begin
						state <= fprint_pkg::st_flush_task;
					end else begin
						state <= fprint_pkg::st_idle;
					end
				end
				fprint_pkg::st_compare: begin
					if (heads_match) begin
						state <= fprint_pkg::st_pop_heads;
					end else begin
						core_q <= blame_core;
						state <= fprint_pkg::st_record_fault;
					end
				end
				fprint_pkg::st_pop_heads: begin
					if (task_bus.pop_ack)
						state <= fprint_pkg::st_check_task;
				end
				fprint_pkg::st_record_fault: begin
					mismatch_q <= 1'b1;
					state <= fprint_pkg::st_flush_task;
				end
				fprint_pkg::st_flush_task: begin
					if (task_bus.flush_ack)
						state <= fprint_pkg::st_write_status;
				end
				fprint_pkg::st_write_status: begin
					// waits here while the host has no credit
					if (status_ack)
						state <= fprint_pkg::st_idle;
				end
				default: state <= fprint_pkg::st_idle;
			endcase
		end
	end

	// requests drop in the ack cycle
	assign task_bus.task_id = task_q;
	assign task_bus.pop_req = (state == fprint_pkg::st_pop_heads) && !task_bus.pop_ack;
	assign task_bus.flush_req = (state == fprint_pkg::st_flush_task) && !task_bus.flush_ack;

	assign status_write = (state == fprint_pkg::st_write_status);
	assign status_rec.task_id = task_q;
	assign status_rec.core = core_q;
	assign status_rec.mismatch = mismatch_q;

endmodule

// File: fprint_status.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_status (
	input logic clk,
	input logic reset,
	input logic status_write,
	input fprint_pkg::status_rec_t status_rec,
	output logic status_ack,
	input logic status_credit,
	output logic status_valid,
	output fprint_pkg::status_rec_t status_out
);

	logic [`FP_CREDIT_W-1:0] credits;

	// grant only while the host has room
	assign status_ack = status_write && (credits != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			credits <= `FP_CREDIT_W'(`FP_STATUS_CREDITS);
			status_valid <= 1'b0;
		end else begin
			status_valid <= status_ack;
			// grant and return together cancel out
			if (status_ack && !status_credit)
				credits <= credits - 1'b1;
			else if (!status_ack && status_credit)
				credits <= credits + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (status_ack)
			status_out <= status_rec;
	end

endmodule

// File: fprint_checker_top.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_checker_top (
	input logic clk,
	input logic reset,
	input logic mode_tmr,
	input logic fp_valid,
	input logic [1:0] fp_core,
	input logic [`FP_TASK_W-1:0] fp_task,
	input logic [`FP_CRC_W-1:0] fp_crc,
	input logic done_valid,
	input logic [1:0] done_core,
	input logic [`FP_TASK_W-1:0] done_task,
	output logic status_valid,
	output logic [`FP_TASK_W-1:0] status_task,
	output logic [1:0] status_core,
	output logic status_mismatch,
	input logic status_credit,
	output logic overflow_error
);

	fprint_task_if task_bus ();

	logic status_write;
	logic status_ack;
	fprint_pkg::status_rec_t status_rec;
	fprint_pkg::status_rec_t status_out;

	fprint_store u_store (
		.clk(clk),
		.reset(reset),
		.mode_tmr(mode_tmr),
		.fp_valid(fp_valid),
		.fp_core(fp_core),
		.fp_task(fp_task),
		.fp_crc(fp_crc),
		.done_valid(done_valid),
		.done_core(done_core),
		.done_task(done_task),
		.task_bus(task_bus.store),
		.overflow_error(overflow_error)
	);

	fprint_comparator u_comparator (
		.clk(clk),
		.reset(reset),
		.mode_tmr(mode_tmr),
		.task_bus(task_bus.comparator),
		.status_write(status_write),
		.status_rec(status_rec),
		.status_ack(status_ack)
	);

	fprint_status u_status (
		.clk(clk),
		.reset(reset),
		.status_write(status_write),
		.status_rec(status_rec),
		.status_ack(status_ack),
		.status_credit(status_credit),
		.status_valid(status_valid),
		.status_out(status_out)
	);

	// record fields to host pins
	assign status_task = status_out.task_id;
	assign status_core = status_out.core;
	assign status_mismatch = status_out.mismatch;

endmodule

// File: fprint_checker_sva.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_checker_sva (
	input logic clk,
	input logic reset,
	input logic status_valid,
	input logic [1:0] status_core,
	input logic status_mismatch,
	input logic status_credit,
	input logic overflow_error,
	input logic [`FP_CREDIT_W-1:0] credits
);

	int fail_count;
	int host_credits;

	// credits as the host counts them at the pins
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			host_credits <= `FP_STATUS_CREDITS;
		else if (status_valid && !status_credit)
			host_credits <= host_credits - 1;
		else if (!status_valid && status_credit)
			host_credits <= host_credits + 1;
	end

	valid_has_credit: assert property (@(posedge clk) disable iff (reset)
		status_valid |-> host_credits > 0)
	else begin
		$error("status record sent with no host credit");
		fail_count++;
	end

	credits_bounded: assert property (@(posedge clk) disable iff (reset)
		credits <= `FP_CREDIT_W'(`FP_STATUS_CREDITS))
	else begin
		$error("credit counter above its maximum");
		fail_count++;
	end

	clean_has_no_core: assert property (@(posedge clk) disable iff (reset)
		status_valid && !status_mismatch |-> status_core == 2'd3)
	else begin
		$error("clean record names a faulty core");
		fail_count++;
	end

	no_overflow: assert property (@(posedge clk) disable iff (reset)
		!overflow_error)
	else begin
		$error("fingerprint buffer overflow");
		fail_count++;
	end

endmodule

bind fprint_checker_top fprint_checker_sva u_sva (
	.clk(clk),
	.reset(reset),
	.status_valid(status_valid),
	.status_core(status_core),
	.status_mismatch(status_mismatch),
	.status_credit(status_credit),
	.overflow_error(overflow_error),
	.credits(u_status.credits)
);

// File: fprint_checker_tb.sv
`timescale 1ns/1ps
`include "fprint_defines.svh"

module fprint_checker_tb;

	localparam int task_cycles = 80;
	// 15 tasks in all, two quiet windows of 100 cycles, reset and margin
	localparam int run_cycles = 10 + 15 * task_cycles + 2 * 100 + 400;

	logic clk;
	logic reset;
	logic mode_tmr;
	logic fp_valid;
	logic [1:0] fp_core;
	logic [`FP_TASK_W-1:0] fp_task;
	logic [`FP_CRC_W-1:0] fp_crc;
	logic done_valid;
	logic [1:0] done_core;
	logic [`FP_TASK_W-1:0] done_task;
	logic status_valid;
	logic [`FP_TASK_W-1:0] status_task;
	logic [1:0] status_core;
	logic status_mismatch;
	logic status_credit;
	logic overflow_error;

	logic auto_credit;
	logic credit_req;
	logic [31:0] rng;
	logic [`FP_CRC_W-1:0] fps [3][`FP_DEPTH];
	int fp_cnt [3];
	fprint_pkg::status_rec_t exp_q [$];
	int exp_total;
	int rec_seen;
	int seq_errors;
	int mon_errors;
	int err_mark;
	int passed;
	int failed;

	fprint_checker_top uut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// host returns one credit per record unless held back
	always @(posedge clk)
		status_credit <= credit_req || (auto_credit && status_valid === 1'b1);

	// records must come out in the queued order
	always @(posedge clk) begin
		fprint_pkg::status_rec_t want;
		int bad;
		bad = 0;
		if (!reset && status_valid) begin
			if (exp_q.size() == 0) begin
				$display("unexpected status record for task %0d at %0t", status_task, $time);
				bad = 1;
			end else begin
				want = exp_q.pop_front();
				assert (status_task == want.task_id) else begin
					$display("FAIL %0t status_task expected %0d got %0d",
						$time, want.task_id, status_task);
					bad++;
				end
				assert (status_core == want.core) else begin
					$display("FAIL %0t status_core expected %0d got %0d",
						$time, want.core, status_core);
					bad++;
				end
				assert (status_mismatch == want.mismatch) else begin
					$display("FAIL %0t status_mismatch expected %0d got %0d",
						$time, want.mismatch, status_mismatch);
					bad++;
				end
			end
			rec_seen <= rec_seen + 1;
		end
		mon_errors <= mon_errors + bad;
	end

	// cores report from the highest down, so the task only turns ready
	// once core 0 starts and everything is stored before the first compare
	task load_task(input int t);
		for (int c = 2; c >= 0; c--) begin
			if (c < 2 || mode_tmr) begin
				for (int i = 0; i < fp_cnt[c]; i++) begin
					@(posedge clk);
					fp_valid <= 1'b1;
					fp_core <= 2'(c);
					fp_task <= `FP_TASK_W'(t);
					fp_crc <= fps[c][i];
				end
				@(posedge clk);
				fp_valid <= 1'b0;
				done_valid <= 1'b1;
				done_core <= 2'(c);
				done_task <= `FP_TASK_W'(t);
			end
		end
		@(posedge clk);
		done_valid <= 1'b0;
	endtask

	// same random fingerprints on every core
	task clean_set(input int n);
		for (int i = 0; i < n; i++) begin
			rng = xorshift(rng);
			for (int c = 0; c < 3; c++)
				fps[c][i] = rng[`FP_CRC_W-1:0];
		end
		for (int c = 0; c < 3; c++)
			fp_cnt[c] = n;
	endtask

	task expect_rec(input int t, input int core, input logic mismatch);
		fprint_pkg::status_rec_t r;
		r.task_id = `FP_TASK_W'(t);
		r.core = 2'(core);
		r.mismatch = mismatch;
		exp_q.push_back(r);
		exp_total++;
	endtask

	task wait_records(input int target);
		int n;
		n = 0;
		while (rec_seen < target && n < task_cycles) begin
			@(posedge clk);
			n++;
		end
		if (rec_seen < target) begin
			$display("timed out at %0t waiting for status record %0d", $time, target);
			seq_errors++;
		end
	endtask

	task credit_pulse;
		@(posedge clk);
		credit_req <= 1'b1;
		@(posedge clk);
		credit_req <= 1'b0;
	endtask

	function automatic int error_total();
		return seq_errors + mon_errors + uut.u_sva.fail_count;
	endfunction

	task end_test(input int num, input string name);
		if (error_total() == err_mark) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: failed", num, name);
		end
		err_mark = error_total();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mode_tmr = 1'b0;
		fp_valid = 1'b0;
		fp_core = '0;
		fp_task = '0;
		fp_crc = '0;
		done_valid = 1'b0;
		done_core = '0;
		done_task = '0;
		status_credit = 1'b0;
		credit_req = 1'b0;
		auto_credit = 1'b1;
		rng = 32'd67;
		exp_total = 0;
		rec_seen = 0;
		seq_errors = 0;
		mon_errors = 0;
		err_mark = 0;
		passed = 0;
		failed = 0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (3) @(posedge clk);

		clean_set(3);
		expect_rec(1, 3, 1'b0);
		load_task(1);
		wait_records(exp_total);
		end_test(1, "dmr clean task");

		clean_set(3);
		fps[1][1] = ~fps[1][1];
		expect_rec(1, 3, 1'b1);
		load_task(1);
		wait_records(exp_total);
		// the flushed task must come back clean
		clean_set(3);
		expect_rec(1, 3, 1'b0);
		load_task(1);
		wait_records(exp_total);
		end_test(2, "dmr mismatch then clean rerun");

		@(posedge clk);
		mode_tmr <= 1'b1;
		@(posedge clk);
		clean_set(3);
		fps[2][2] = ~fps[2][2];
		expect_rec(2, 2, 1'b1);
		load_task(2);
		wait_records(exp_total);
		clean_set(3);
		fps[0][1] = ~fps[0][1];
		expect_rec(2, 0, 1'b1);
		load_task(2);
		wait_records(exp_total);
		end_test(3, "tmr single faulty core");

		@(posedge clk);
		mode_tmr <= 1'b0;
		@(posedge clk);
		clean_set(4);
		fp_cnt[1] = 3;
		expect_rec(3, 0, 1'b1);
		load_task(3);
		wait_records(exp_total);
		end_test(4, "uneven fingerprint count");

		// two records use up the credits and task 1 then parks in write_status
		auto_credit <= 1'b0;
		for (int i = 0; i < 2; i++) begin
			clean_set(2);
			expect_rec(i + 1, 3, 1'b0);
			load_task(i + 1);
			wait_records(exp_total);
		end
		expect_rec(1, 3, 1'b0);
		expect_rec(0, 3, 1'b0);
		expect_rec(3, 3, 1'b0);
		clean_set(2);
		load_task(1);
		clean_set(2);
		load_task(3);
		clean_set(2);
		load_task(0);
		repeat (100) @(posedge clk);
		assert (rec_seen == exp_total - 3) else begin
			$display("status records went out while the host held no credit");
			seq_errors++;
		end
		for (int k = 2; k >= 0; k--) begin
			credit_pulse();
			wait_records(exp_total - k);
		end
		credit_pulse();
		credit_pulse();
		end_test(5, "task priority under zero credits");

		for (int t = 0; t < 4; t++) begin
			clean_set(2);
			expect_rec(t, 3, 1'b0);
			load_task(t);
		end
		repeat (100) @(posedge clk);
		assert (rec_seen == exp_total - 2) else begin
			$display("expected exactly two records before credits returned, saw %0d",
				rec_seen + 4 - exp_total);
			seq_errors++;
		end
		for (int k = 1; k >= 0; k--) begin
			credit_pulse();
			wait_records(exp_total - k);
		end
		end_test(6, "credit back-pressure");

		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, error_total());
		if (failed == 0 && error_total() == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		#(run_cycles * 10);
		$display("watchdog: run still busy after %0d cycles", run_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: fprint_checker.f
+incdir+.
fprint_pkg.sv
fprint_task_if.sv
fprint_store.sv
fprint_comparator.sv
fprint_status.sv
fprint_checker_top.sv
fprint_checker_sva.sv
fprint_checker_tb.sv

// File: Bender.yml
package:
  name: fprint_checker

sources:
  - include_dirs:
      - .
    files:
      - fprint_pkg.sv
      - fprint_task_if.sv
      - fprint_store.sv
      - fprint_comparator.sv
      - fprint_status.sv
      - fprint_checker_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fprint_checker_sva.sv
      - fprint_checker_tb.sv
